// File: vlog.f
+incdir+verification
common/hit_pkg.sv
hdl/vec_fifo.sv
hdl/dot3.sv
hdl/plane_offset.sv
hdl/ray_dot.sv
divider/fixed_divide.sv
hdl/ray_hit_top.sv
verification/ray_hit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the ray hit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module ray_hit_tb -o ray_hit_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/ray_hit_sim > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see $SIM_LOG"
    exit 1
fi

if grep -qx "all tests passed" "$SIM_LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL, see $SIM_LOG"
exit 1

// File: verification/ray_hit_model.svh
`ifndef RAY_HIT_MODEL_SVH
`define RAY_HIT_MODEL_SVH

// each product rescaled and cut to 32 bits, sum wraps
function automatic hit_pkg::fixed_t model_dot(input hit_pkg::vec3_t a, input hit_pkg::vec3_t b);
    longint          p;
    hit_pkg::fixed_t acc;
    acc = '0;
    p   = longint'(a.x) * longint'(b.x);
    acc = acc + hit_pkg::fixed_t'(p >>> Q_BITS);
    p   = longint'(a.y) * longint'(b.y);
    acc = acc + hit_pkg::fixed_t'(p >>> Q_BITS);
    p   = longint'(a.z) * longint'(b.z);
    acc = acc + hit_pkg::fixed_t'(p >>> Q_BITS);
    return acc;
endfunction

// truncating divide on magnitudes, saturate on zero divisor
function automatic hit_pkg::fixed_t model_divide(input hit_pkg::fixed_t num,
                                                 input hit_pkg::fixed_t den);
    longint unsigned mag_n, mag_d, q;
    if (den == 0) begin
        return (num < 0) ? 32'sh8000_0001 : 32'sh7fff_ffff;
    end
    mag_n = (num < 0) ? -longint'(num) : longint'(num);
    mag_d = (den < 0) ? -longint'(den) : longint'(den);
    q     = (mag_n << Q_BITS) / mag_d;
    if ((num < 0) != (den < 0)) begin
        q = -q;
    end
    return q[31:0];  // low word only
endfunction

function automatic hit_pkg::fixed_t model_t(input hit_pkg::hit_query_t q);
    hit_pkg::fixed_t num;
    num = model_dot(q.normal, q.v0) - model_dot(q.normal, q.origin);
    return model_divide(num, model_dot(q.normal, q.dir));
endfunction

task automatic check_t(input hit_pkg::fixed_t got, input hit_pkg::fixed_t exp,
                       input string what);
    if (got !== exp) begin
        errors++;
        $display("Error at %0t: %s t = %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        errors++;
        $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

`endif

// File: verification/ray_hit_tb.sv
`timescale 1ns/1ps

module ray_hit_tb;

    localparam int Q_BITS     = 16;
    localparam int FIFO_DEPTH = 16;
    localparam int WAIT_LIMIT = 2000;          // cycles per wait loop
    localparam int LIM        = 64 << Q_BITS;  // +-64.0

    logic                clock;
    logic                arst_n;
    hit_pkg::hit_query_t query;
    logic                in_wr_en;
    logic                in_full;
    hit_pkg::fixed_t     t;
    logic                out_empty;
    logic                out_rd_en;

    logic [31:0]         rng;
    hit_pkg::fixed_t     sb_q[$];  // expected t in input order
    hit_pkg::hit_query_t stim[256];
    int                  gap_wr[256];
    int                  gap_rd[256];
    int                  errors, tests_run, tests_failed;
    int                  errs_before, sent;
    logic                full_seen;

    `include "ray_hit_model.svh"

    ray_hit_top #(
        .Q_BITS     (Q_BITS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut0 (
        .clock      (clock),
        .arst_n     (arst_n),
        .query      (query),
        .in_wr_en   (in_wr_en),
        .in_full    (in_full),
        .t          (t),
        .out_empty  (out_empty),
        .out_rd_en  (out_rd_en)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic hit_pkg::fixed_t rand_fixed();
        hit_pkg::fixed_t v;
        v = hit_pkg::fixed_t'(next_rand() % (2 * LIM + 1));
        return v - LIM;
    endfunction

    function automatic hit_pkg::vec3_t rand_vec();
        hit_pkg::vec3_t v;
        v.x = rand_fixed();
        v.y = rand_fixed();
        v.z = rand_fixed();
        return v;
    endfunction

    function automatic hit_pkg::hit_query_t rand_query();
        hit_pkg::hit_query_t q;
        q.normal = rand_vec();
        q.v0     = rand_vec();
        q.origin = rand_vec();
        q.dir    = rand_vec();
        return q;
    endfunction

    // whole units to Q format
    function automatic hit_pkg::vec3_t vec_of(input int x, input int y, input int z);
        hit_pkg::vec3_t v;
        v.x = x <<< Q_BITS;
        v.y = y <<< Q_BITS;
        v.z = z <<< Q_BITS;
        return v;
    endfunction

    function automatic hit_pkg::hit_query_t query_of(input hit_pkg::vec3_t n,
            input hit_pkg::vec3_t v0, input hit_pkg::vec3_t o, input hit_pkg::vec3_t d);
        hit_pkg::hit_query_t q;
        q.normal = n;
        q.v0     = v0;
        q.origin = o;
        q.dir    = d;
        return q;
    endfunction

    task automatic abort_on_timeout(input string what);
        $display("timeout: no %s within %0d cycles at %0t", what, WAIT_LIMIT, $time);
        $display("tests failed");
        $finish;
    endtask

    task automatic send_query(input hit_pkg::hit_query_t q);
        int waited;
        waited = 0;
        @(negedge clock);
        while (in_full) begin
            waited++;
            if (waited > WAIT_LIMIT) abort_on_timeout("free input slot");
            @(negedge clock);
        end
        @(posedge clock);
        query    <= q;
        in_wr_en <= 1'b1;
        sb_q.push_back(model_t(q));
        @(posedge clock);
        in_wr_en <= 1'b0;
    endtask

    task automatic recv_result(input string what);
        int              waited;
        hit_pkg::fixed_t exp_t;
        waited = 0;
        @(negedge clock);
        while (out_empty) begin
            waited++;
            if (waited > WAIT_LIMIT) abort_on_timeout("result");
            @(negedge clock);
        end
        if (sb_q.size() == 0) begin
            errors++;
            $display("result %h came out with no query outstanding at %0t", t, $time);
        end else begin
            exp_t = sb_q.pop_front();
            check_t(t, exp_t, what);
        end
        @(posedge clock);
        out_rd_en <= 1'b1;
        @(posedge clock);
        out_rd_en <= 1'b0;
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        tests_run++;
        if (errors == errs_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED", tests_run, name);
        end
    endtask

    initial begin
        rng          = 32'hc35f_b862;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        arst_n       = 1'b0;
        query        = '0;
        in_wr_en     = 1'b0;
        out_rd_en    = 1'b0;
        repeat (4) @(posedge clock);
        arst_n <= 1'b1;

        errs_before = errors;
        @(negedge clock);
        check_flag(out_empty, 1'b1, "out_empty after reset");
        check_flag(in_full, 1'b0, "in_full after reset");
        end_test("reset flags", errs_before);

        errs_before = errors;
        for (int i = 0; i < 200; i++) stim[i] = rand_query();
        fork
            for (int i = 0; i < 200; i++) send_query(stim[i]);
            repeat (200) recv_result("random query");
        join
        end_test("random queries", errs_before);

        // no reads until the input backs up
        errs_before = errors;
        sent        = 0;
        full_seen   = 1'b0;
        while (!full_seen && sent < 64) begin
            send_query(rand_query());
            sent++;
            @(negedge clock);
            full_seen = in_full;
        end
        check_flag(full_seen, 1'b1, "in_full under back-pressure");
        while (sb_q.size() > 0) recv_result("drain");
        @(negedge clock);
        check_flag(out_empty, 1'b1, "out_empty after drain");
        end_test("back-pressure", errs_before);

        errs_before = errors;
        send_query(query_of(vec_of(1, 0, 0), vec_of(5, 0, 0), vec_of(2, 0, 0), vec_of(0, 0, 0)));
        send_query(query_of(vec_of(1, 0, 0), vec_of(2, 0, 0), vec_of(5, 0, 0), vec_of(0, 0, 0)));
        send_query(query_of(vec_of(0, 2, 0), vec_of(0, 7, 0), vec_of(0, 1, 0), vec_of(3, 0, -2)));
        send_query(query_of(vec_of(0, 2, 0), vec_of(0, 1, 0), vec_of(0, 7, 0), vec_of(3, 0, -2)));
        repeat (4) recv_result("zero denominator");
        end_test("zero denominator", errs_before);

        // all four sign pairs of n.v0 and n.d
        errs_before = errors;
        send_query(query_of(vec_of(1, 0, 0), vec_of(10, 0, 0), vec_of(0, 0, 0), vec_of(4, 1, 1)));
        send_query(query_of(vec_of(1, 0, 0), vec_of(10, 0, 0), vec_of(0, 0, 0), vec_of(-4, 1, 1)));
        send_query(query_of(vec_of(1, 0, 0), vec_of(-10, 0, 0), vec_of(0, 0, 0), vec_of(4, 1, 1)));
        send_query(query_of(vec_of(1, 0, 0), vec_of(-10, 0, 0), vec_of(0, 0, 0), vec_of(-4, 1, 1)));
        repeat (4) recv_result("sign combination");
        end_test("sign rule", errs_before);

        errs_before = errors;
        for (int i = 0; i < 100; i++) begin
            stim[i]   = rand_query();
            gap_wr[i] = next_rand() % 4;
            gap_rd[i] = next_rand() % 5;
        end
        fork
            for (int i = 0; i < 100; i++) begin
                repeat (gap_wr[i]) @(posedge clock);
                send_query(stim[i]);
            end
            for (int i = 0; i < 100; i++) begin
                repeat (gap_rd[i]) @(posedge clock);
                recv_result("mixed traffic");
            end
        join
        check_flag(sb_q.size() == 0, 1'b1, "scoreboard empty");
        @(negedge clock);
        check_flag(out_empty, 1'b1, "out_empty after mixed traffic");
        end_test("mixed gaps", errs_before);

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: hdl/ray_hit_top.sv
`timescale 1ns/1ps

module ray_hit_top #(
    parameter int Q_BITS     = 16,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                clock,
    input  logic                arst_n,
    input  hit_pkg::hit_query_t query,
    input  logic                in_wr_en,
    output logic                in_full,
    output hit_pkg::fixed_t     t,
    output logic                out_empty,
    input  logic                out_rd_en
);

    hit_pkg::fixed_t num, den;
    logic            num_full, den_full;
    logic            num_empty, den_empty;
    logic            div_empty, div_rd_en;

    assign in_full   = num_full || den_full;  // both stages see every query
    assign div_empty = num_empty || den_empty;

    plane_offset #(
        .Q_BITS       (Q_BITS),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) u_plane_offset (
        .clock        (clock),
        .arst_n       (arst_n),
        .query        (query),
        .in_wr_en     (in_wr_en),
        .in_full      (num_full),
        .out          (num),
        .out_empty    (num_empty),
        .out_rd_en    (div_rd_en)
    );

    ray_dot #(
        .Q_BITS       (Q_BITS),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) u_ray_dot (
        .clock        (clock),
        .arst_n       (arst_n),
        .query        (query),
        .in_wr_en     (in_wr_en),
        .in_full      (den_full),
        .out          (den),
        .out_empty    (den_empty),
        .out_rd_en    (div_rd_en)
    );

    fixed_divide #(
        .Q_BITS       (Q_BITS)
    ) u_fixed_divide (
        .clock        (clock),
        .arst_n       (arst_n),
        .dividend     (num),
        .divisor      (den),
        .in_empty     (div_empty),
        .in_rd_en     (div_rd_en),
        .quotient     (t),
        .out_empty    (out_empty),
        .out_rd_en    (out_rd_en)
    );

endmodule

// File: divider/fixed_divide.sv
`timescale 1ns/1ps

module fixed_divide #(
    parameter int Q_BITS = 16
) (
    input  logic            clock,
    input  logic            arst_n,
    input  hit_pkg::fixed_t dividend,
    input  hit_pkg::fixed_t divisor,
    input  logic            in_empty,
    output logic            in_rd_en,
    output hit_pkg::fixed_t quotient,
    output logic            out_empty,
    input  logic            out_rd_en
);

    localparam int STEPS = 32 + Q_BITS;
    localparam int CW    = $clog2(STEPS + 1);

    hit_pkg::div_state_t state;
    logic [CW-1:0]       count;
    logic [31:0]         dvd_mag, dvs_mag, dvs_q;
    hit_pkg::wide_t      num, quo, quo_signed;
    logic [32:0]         rem, rem_shift;
    logic                neg_q, neg_num, zero_q;
    hit_pkg::fixed_t     result;
    logic                push, out_full;

    assign dvd_mag = dividend[31] ? (~dividend + 32'd1) : dividend;
    assign dvs_mag = divisor[31] ? (~divisor + 32'd1) : divisor;

    assign in_rd_en  = (state == hit_pkg::IDLE) && !in_empty && !out_full;
    assign push      = (state == hit_pkg::PUSH);
    assign rem_shift = {rem[31:0], num[STEPS-1]};  // bring down next numerator bit

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= hit_pkg::IDLE;
            count <= '0;
        end else begin
            case (state)
                hit_pkg::IDLE: if (in_rd_en) begin
                    state <= hit_pkg::RUN;
                    count <= CW'(STEPS - 1);
                end
                hit_pkg::RUN: if (count == '0) begin
                    state <= hit_pkg::PUSH;
                end else begin
                    count <= count - 1'b1;
                end
                default: state <= hit_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            num     <= hit_pkg::wide_t'(dvd_mag) << Q_BITS;  // pre-scale for Q result
            rem     <= '0;
            quo     <= '0;
            dvs_q   <= dvs_mag;
            neg_q   <= dividend[31] ^ divisor[31];
            neg_num <= dividend[31];
            zero_q  <= (divisor == '0);
        end else if (state == hit_pkg::RUN) begin
            num <= num << 1;
            if (rem_shift >= {1'b0, dvs_q}) begin
                rem <= rem_shift - {1'b0, dvs_q};
                quo <= {quo[62:0], 1'b1};
            end else begin
                rem <= rem_shift;
                quo <= {quo[62:0], 1'b0};
            end
        end
    end

    // sign fix, then saturate on divide by zero
    always_comb begin
        quo_signed = neg_q ? -quo : quo;
        if (zero_q) begin
            result = neg_num ? 32'sh8000_0001 : 32'sh7fff_ffff;
        end else begin
            result = quo_signed[31:0];
        end
    end

    vec_fifo #(
        .WIDTH     ($bits(hit_pkg::fixed_t)),
        .DEPTH     (4)
    ) u_quo_fifo (
        .clock     (clock),
        .arst_n    (arst_n),
        .wr_en     (push),
        .din       (result),
        .full      (out_full),
        .rd_en     (out_rd_en),
        .dout      (quotient),
        .empty     (out_empty)
    );

    // quotient lands a fixed latency after the operand pop
    assert property (@(posedge clock) disable iff (!arst_n)
        in_rd_en |-> ##(STEPS + 1) push)
        else $error("fixed_divide: quotient not pushed at fixed latency");

endmodule

// File: hdl/ray_dot.sv
`timescale 1ns/1ps

module ray_dot #(
    parameter int Q_BITS     = 16,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                clock,
    input  logic                arst_n,
    input  hit_pkg::hit_query_t query,
    input  logic                in_wr_en,
    output logic                in_full,
    output hit_pkg::fixed_t     out,
    output logic                out_empty,
    input  logic                out_rd_en
);

    localparam int Q_W = 2 * $bits(hit_pkg::vec3_t);  // normal and dir only

    logic [Q_W-1:0] q_head;
    hit_pkg::vec3_t q_normal, q_dir;
    logic           q_empty, q_rd_en;

    vec_fifo #(
        .WIDTH     (Q_W),
        .DEPTH     (FIFO_DEPTH)
    ) u_query_fifo (
        .clock     (clock),
        .arst_n    (arst_n),
        .wr_en     (in_wr_en),
        .din       ({query.normal, query.dir}),
        .full      (in_full),
        .rd_en     (q_rd_en),
        .dout      (q_head),
        .empty     (q_empty)
    );

    assign {q_normal, q_dir} = q_head;

    dot3 #(
        .Q_BITS    (Q_BITS)
    ) u_dot_nd (
        .clock     (clock),
        .arst_n    (arst_n),
        .a         (q_normal),
        .b         (q_dir),
        .in_empty  (q_empty),
        .in_rd_en  (q_rd_en),
        .out       (out),
        .out_empty (out_empty),
        .out_rd_en (out_rd_en)
    );

endmodule

// File: hdl/plane_offset.sv
`timescale 1ns/1ps

module plane_offset #(
    parameter int Q_BITS     = 16,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                clock,
    input  logic                arst_n,
    input  hit_pkg::hit_query_t query,
    input  logic                in_wr_en,
    output logic                in_full,
    output hit_pkg::fixed_t     out,
    output logic                out_empty,
    input  logic                out_rd_en
);

    localparam int Q_W = 3 * $bits(hit_pkg::vec3_t);  // normal, v0, origin

    logic [Q_W-1:0]  q_head;
    hit_pkg::vec3_t  q_normal, q_v0, q_origin;
    logic            q_empty, q_rd_en;
    logic            nv_rd_en, no_rd_en;
    hit_pkg::fixed_t nv, no, diff;
    logic            nv_empty, no_empty;
    logic            sub_pop, out_full;

    vec_fifo #(
        .WIDTH     (Q_W),
        .DEPTH     (FIFO_DEPTH)
    ) u_query_fifo (
        .clock     (clock),
        .arst_n    (arst_n),
        .wr_en     (in_wr_en),
        .din       ({query.normal, query.v0, query.origin}),
        .full      (in_full),
        .rd_en     (q_rd_en),
        .dout      (q_head),
        .empty     (q_empty)
    );

    assign {q_normal, q_v0, q_origin} = q_head;
    assign q_rd_en = nv_rd_en && no_rd_en;  // dots run in lock step

    dot3 #(
        .Q_BITS    (Q_BITS)
    ) u_dot_nv (
        .clock     (clock),
        .arst_n    (arst_n),
        .a         (q_normal),
        .b         (q_v0),
        .in_empty  (q_empty),
        .in_rd_en  (nv_rd_en),
        .out       (nv),
        .out_empty (nv_empty),
        .out_rd_en (sub_pop)
    );

    dot3 #(
        .Q_BITS    (Q_BITS)
    ) u_dot_no (
        .clock     (clock),
        .arst_n    (arst_n),
        .a         (q_normal),
        .b         (q_origin),
        .in_empty  (q_empty),
        .in_rd_en  (no_rd_en),
        .out       (no),
        .out_empty (no_empty),
        .out_rd_en (sub_pop)
    );

    // n.v0 - n.o
    assign sub_pop = !nv_empty && !no_empty && !out_full;
    assign diff    = nv - no;

    vec_fifo #(
        .WIDTH     ($bits(hit_pkg::fixed_t)),
        .DEPTH     (4)
    ) u_out_fifo (
        .clock     (clock),
        .arst_n    (arst_n),
        .wr_en     (sub_pop),
        .din       (diff),
        .full      (out_full),
        .rd_en     (out_rd_en),
        .dout      (out),
        .empty     (out_empty)
    );

    assert property (@(posedge clock) disable iff (!arst_n) nv_rd_en == no_rd_en)
        else $error("plane_offset: dot pops out of step");

endmodule

// File: hdl/dot3.sv
`timescale 1ns/1ps

module dot3 #(
    parameter int Q_BITS = 16
) (
    input  logic            clock,
    input  logic            arst_n,
    input  hit_pkg::vec3_t  a,
    input  hit_pkg::vec3_t  b,
    input  logic            in_empty,
    output logic            in_rd_en,
    output hit_pkg::fixed_t out,
    output logic            out_empty,
    input  logic            out_rd_en
);

    hit_pkg::wide_t  prod_x, prod_y, prod_z;
    hit_pkg::fixed_t term_x, term_y, term_z;
    hit_pkg::fixed_t sum;
    logic            prod_valid;
    logic            push;
    logic            out_full;

    // full 64-bit products, rescaled back to Q format
    assign prod_x = (hit_pkg::wide_t'(a.x) * hit_pkg::wide_t'(b.x)) >>> Q_BITS;
    assign prod_y = (hit_pkg::wide_t'(a.y) * hit_pkg::wide_t'(b.y)) >>> Q_BITS;
    assign prod_z = (hit_pkg::wide_t'(a.z) * hit_pkg::wide_t'(b.z)) >>> Q_BITS;

    assign in_rd_en = !in_empty && !out_full;
    assign push     = prod_valid && !out_full;  // stalls in the register if full
    assign sum      = term_x + term_y + term_z;  // wraps in 32 bits

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            prod_valid <= 1'b0;
        end else if (in_rd_en) begin
            prod_valid <= 1'b1;
        end else if (push) begin
            prod_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            term_x <= prod_x[31:0];
            term_y <= prod_y[31:0];
            term_z <= prod_z[31:0];
        end
    end

    vec_fifo #(
        .WIDTH     ($bits(hit_pkg::fixed_t)),
        .DEPTH     (4)
    ) u_out_fifo (
        .clock     (clock),
        .arst_n    (arst_n),
        .wr_en     (push),
        .din       (sum),
        .full      (out_full),
        .rd_en     (out_rd_en),
        .dout      (out),
        .empty     (out_empty)
    );

endmodule

// File: hdl/vec_fifo.sv
`timescale 1ns/1ps

module vec_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic             clock,
    input  logic             arst_n,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    output logic             full,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr, rd_ptr;
    logic [CW-1:0]    count;
    logic             do_wr, do_rd;

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign full  = (count == CW'(DEPTH));
    assign empty = (count == '0);
    assign dout  = mem[rd_ptr];  // head word, fall-through

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    assert property (@(posedge clock) disable iff (!arst_n) wr_en |-> !full)
        else $error("vec_fifo: write while full");
    assert property (@(posedge clock) disable iff (!arst_n) rd_en |-> !empty)
        else $error("vec_fifo: read while empty");

endmodule

// File: common/hit_pkg.sv
package hit_pkg;

    // signed fixed point, fraction width set per module by Q_BITS
    typedef logic signed [31:0] fixed_t;

    // full-width products and partial quotients
    typedef logic signed [63:0] wide_t;

    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
    } vec3_t;

    typedef struct packed {
        vec3_t normal;
        vec3_t v0;
        vec3_t origin;
        vec3_t dir;
    } hit_query_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        PUSH
    } div_state_t;

endpackage
